//--- rx_axis_out.sv
`timescale 1ns/1ps

// AXI-stream output register with frame counters
module rx_axis_out (
    input  logic                  clk,
    input  logic                  rst,
    input  rx_mac_pkg::rx_entry_t rd_entry,
    input  logic                  empty,
    output logic                  rd_en,
    output rx_mac_pkg::byte_t     tdata,
    output logic                  tvalid,
    output logic                  tlast,
    output logic                  tuser,
    input  logic                  trdy,
    output rx_mac_pkg::rx_stats_t stats
);

    logic load;
    logic xfer;

    // Beat leaves on this edge
    assign xfer = tvalid && trdy;

    // Register is free now or frees up on this edge
    assign load = !tvalid || trdy;

    // Pop the FIFO head straight into the register
    assign rd_en = load && !empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            tvalid <= 1'b0;
        end else if (load) begin
            tvalid <= !empty;
        end
    end

    // Beat contents hold while tvalid waits for trdy
    always_ff @(posedge clk) begin
        if (rd_en) begin
            tdata <= rd_entry.data;
            tlast <= rd_entry.last;
            // Bad-frame flag only rides on the closing beat
            tuser <= rd_entry.last && rd_entry.error;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stats <= '0;
        end else if (xfer && tlast) begin
            stats.frame_count <= stats.frame_count + 32'd1;
            if (tuser) begin
                stats.bad_frame_count <= stats.bad_frame_count + 32'd1;
            end
        end
    end

endmodule

//--- rx_crc32.sv
`timescale 1ns/1ps

// Reflected CRC-32 over one byte, LSB of the byte first
module rx_crc32 (
    input  rx_mac_pkg::crc_t  crc_in,
    input  rx_mac_pkg::byte_t data,
    output rx_mac_pkg::crc_t  crc_out
);

    // stage[0] is the incoming value, stage[8] the result
    rx_mac_pkg::crc_t stage [0:8];

    assign stage[0] = crc_in;

    // One shift and conditional XOR per data bit
    for (genvar i = 0; i < 8; i++) begin : g_bit
        logic feedback;

        assign feedback = stage[i][0] ^ data[i];

        always_comb begin
            if (feedback) begin
                stage[i+1] = (stage[i] >> 1) ^ rx_mac_pkg::CRC_POLY;
            end else begin
                stage[i+1] = stage[i] >> 1;
            end
        end
    end

    assign crc_out = stage[8];

endmodule

//--- rx_frame_fifo.sv
`timescale 1ns/1ps

// Show-ahead FIFO of frame entries
module rx_frame_fifo (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wr_en,
    input  rx_mac_pkg::rx_entry_t wr_entry,
    input  logic                  rd_en,
    output rx_mac_pkg::rx_entry_t rd_entry,
    output logic                  empty,
    output logic                  almost_full
);

    rx_mac_pkg::rx_entry_t mem [rx_mac_pkg::FIFO_DEPTH];

    rx_mac_pkg::fifo_ptr_t   wr_ptr;
    rx_mac_pkg::fifo_ptr_t   rd_ptr;
    rx_mac_pkg::fifo_count_t count;

    logic full;
    logic do_wr;
    logic do_rd;

    assign full  = (count == rx_mac_pkg::fifo_count_t'(rx_mac_pkg::FIFO_DEPTH));
    assign empty = (count == '0);

    // Never overwrite a stored entry or pop an empty FIFO
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    // Counts the write landing this cycle, since the producer
    // decides one cycle ahead of its write
    assign almost_full = (count + rx_mac_pkg::fifo_count_t'(wr_en))
                         >= rx_mac_pkg::FIFO_AF_LEVEL;

    // Head entry is visible before it is popped
    assign rd_entry = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap on their own at 64
            if (do_wr) begin
                wr_ptr <= wr_ptr + 6'd1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 6'd1;
            end

            case ({do_wr, do_rd})
                2'b10:   count <= count + 7'd1;
                2'b01:   count <= count - 7'd1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- rx_frame_parser.sv
`timescale 1ns/1ps

module rx_frame_parser (
    input  logic                  clk,
    input  logic                  rst,
    input  rx_mac_pkg::byte_t     rx_data,
    input  logic                  rx_dv,
    input  logic                  rx_er,
    input  logic                  almost_full,
    output logic                  wr_en,
    output rx_mac_pkg::rx_entry_t wr_entry
);

    rx_mac_pkg::parser_state_t state;

    // Running CRC over data and FCS bytes
    rx_mac_pkg::crc_t crc;
    rx_mac_pkg::crc_t crc_next;

    // Last four bytes, which may turn out to be the FCS
    rx_mac_pkg::byte_t dly [rx_mac_pkg::FCS_BYTES];
    // Oldest byte, known to be payload once a fifth byte arrived
    rx_mac_pkg::byte_t hold;

    // Bytes since the SFD, stops at MIN_FRAME_BYTES
    rx_mac_pkg::frame_cnt_t byte_cnt;

    logic err_seen;
    // At least one entry of this frame is already in the FIFO
    logic wrote;
    logic hold_valid;

    assign hold_valid = (byte_cnt == rx_mac_pkg::MIN_FRAME_BYTES);

    rx_crc32 u_crc (
        .crc_in  (crc),
        .data    (rx_data),
        .crc_out (crc_next)
    );

    // Delay line and held byte carry payload only
    always_ff @(posedge clk) begin
        if (state == rx_mac_pkg::ST_DATA && rx_dv) begin
            dly[0] <= rx_data;
            for (int i = 1; i < rx_mac_pkg::FCS_BYTES; i++) begin
                dly[i] <= dly[i-1];
            end
            if (byte_cnt >= rx_mac_pkg::FCS_BYTES) begin
                hold <= dly[rx_mac_pkg::FCS_BYTES-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= rx_mac_pkg::ST_IDLE;
            crc      <= rx_mac_pkg::CRC_INIT;
            byte_cnt <= '0;
            err_seen <= 1'b0;
            wrote    <= 1'b0;
            wr_en    <= 1'b0;
        end else begin
            wr_en <= 1'b0;

            case (state)
                rx_mac_pkg::ST_IDLE: begin
                    if (rx_dv) begin
                        err_seen <= rx_er;
                        if (rx_data == rx_mac_pkg::PREAMBLE_BYTE) begin
                            state <= rx_mac_pkg::ST_PREAMBLE;
                        end else begin
                            state <= rx_mac_pkg::ST_DROP;
                        end
                    end
                end

                rx_mac_pkg::ST_PREAMBLE: begin
                    if (!rx_dv) begin
                        // Frame ended before any SFD
                        state <= rx_mac_pkg::ST_IDLE;
                    end else begin
                        err_seen <= err_seen | rx_er;
                        if (rx_data == rx_mac_pkg::SFD_BYTE) begin
                            state    <= rx_mac_pkg::ST_DATA;
                            crc      <= rx_mac_pkg::CRC_INIT;
                            byte_cnt <= '0;
                            wrote    <= 1'b0;
                        end else if (rx_data != rx_mac_pkg::PREAMBLE_BYTE) begin
                            state <= rx_mac_pkg::ST_DROP;
                        end
                    end
                end

                rx_mac_pkg::ST_DATA: begin
                    if (rx_dv) begin
                        err_seen <= err_seen | rx_er;
                        crc      <= crc_next;
                        if (!hold_valid) begin
                            byte_cnt <= byte_cnt + 3'd1;
                        end
                        // Held byte is payload, push it out
                        if (hold_valid) begin
                            wr_entry.data <= hold;
                            if (almost_full) begin
                                // Cut the frame short and mark it bad
                                state          <= rx_mac_pkg::ST_DROP;
                                wr_en          <= wrote;
                                wr_entry.last  <= 1'b1;
                                wr_entry.error <= 1'b1;
                            end else begin
                                wr_en          <= 1'b1;
                                wr_entry.last  <= 1'b0;
                                wr_entry.error <= 1'b0;
                                wrote          <= 1'b1;
                            end
                        end
                    end else begin
                        state <= rx_mac_pkg::ST_IDLE;
                        // Close the frame with its final payload byte
                        if (hold_valid && !(almost_full && !wrote)) begin
                            wr_en          <= 1'b1;
                            wr_entry.data  <= hold;
                            wr_entry.last  <= 1'b1;
                            wr_entry.error <= err_seen | almost_full |
                                              (crc != rx_mac_pkg::CRC_RESIDUE);
                        end
                    end
                end

                rx_mac_pkg::ST_DROP: begin
                    if (!rx_dv) begin
                        state <= rx_mac_pkg::ST_IDLE;
                    end
                end

                default: begin
                    state <= rx_mac_pkg::ST_IDLE;
                end
            endcase
        end
    end

endmodule

//--- rx_mac.sv
`timescale 1ns/1ps

// Ethernet MAC receive path
module rx_mac (
    input  logic                  clk,
    input  logic                  rst,
    input  rx_mac_pkg::byte_t     rgmii_mac_rx_data,
    input  logic                  rgmii_mac_rx_dv,
    input  logic                  rgmii_mac_rx_er,
    output rx_mac_pkg::byte_t     m_rx_axis_tdata,
    output logic                  m_rx_axis_tvalid,
    output logic                  m_rx_axis_tlast,
    output logic                  m_rx_axis_tuser,
    input  logic                  s_rx_axis_trdy,
    output rx_mac_pkg::rx_stats_t stats
);

    // Parser to FIFO
    logic                  wr_en;
    rx_mac_pkg::rx_entry_t wr_entry;
    logic                  almost_full;

    // FIFO to output stage
    logic                  rd_en;
    rx_mac_pkg::rx_entry_t rd_entry;
    logic                  fifo_empty;

    rx_frame_parser u_parser (
        .clk         (clk),
        .rst         (rst),
        .rx_data     (rgmii_mac_rx_data),
        .rx_dv       (rgmii_mac_rx_dv),
        .rx_er       (rgmii_mac_rx_er),
        .almost_full (almost_full),
        .wr_en       (wr_en),
        .wr_entry    (wr_entry)
    );

    rx_frame_fifo u_fifo (
        .clk         (clk),
        .rst         (rst),
        .wr_en       (wr_en),
        .wr_entry    (wr_entry),
        .rd_en       (rd_en),
        .rd_entry    (rd_entry),
        .empty       (fifo_empty),
        .almost_full (almost_full)
    );

    rx_axis_out u_axis (
        .clk      (clk),
        .rst      (rst),
        .rd_entry (rd_entry),
        .empty    (fifo_empty),
        .rd_en    (rd_en),
        .tdata    (m_rx_axis_tdata),
        .tvalid   (m_rx_axis_tvalid),
        .tlast    (m_rx_axis_tlast),
        .tuser    (m_rx_axis_tuser),
        .trdy     (s_rx_axis_trdy),
        .stats    (stats)
    );

endmodule

//--- rx_mac_pkg.sv
package rx_mac_pkg;

    // Data and CRC widths
    typedef logic [7:0]  byte_t;
    typedef logic [31:0] crc_t;

    // Byte count inside a frame, wide enough for the capped count
    typedef logic [2:0]  frame_cnt_t;

    // FIFO index and fill level
    typedef logic [5:0]  fifo_ptr_t;
    typedef logic [6:0]  fifo_count_t;

    // Statistics counter
    typedef logic [31:0] count_t;

    // Reflected CRC-32 (IEEE 802.3)
    localparam crc_t CRC_POLY    = 32'hEDB8_8320;
    localparam crc_t CRC_INIT    = 32'hFFFF_FFFF;
    // Register value after data plus a correct FCS, no final inversion
    localparam crc_t CRC_RESIDUE = 32'hDEBB_20E3;

    // Ethernet framing
    localparam byte_t PREAMBLE_BYTE = 8'h55;
    localparam byte_t SFD_BYTE      = 8'hD5;

    localparam frame_cnt_t FCS_BYTES       = 3'd4;
    // Shortest frame that carries data: one payload byte plus the FCS
    localparam frame_cnt_t MIN_FRAME_BYTES = 3'd5;

    // Frame FIFO
    localparam int FIFO_DEPTH = 64;
    // Level of stored plus in-flight entries at which the next write
    // would leave at most one slot free
    localparam fifo_count_t FIFO_AF_LEVEL = fifo_count_t'(FIFO_DEPTH - 2);

    // One FIFO word
    typedef struct packed {
        byte_t data;
        logic  last;
        logic  error;
    } rx_entry_t;

    // Frame statistics
    typedef struct packed {
        count_t frame_count;
        count_t bad_frame_count;
    } rx_stats_t;

    // Receive parser states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PREAMBLE,
        ST_DATA,
        ST_DROP
    } parser_state_t;

endpackage

//--- rx_mac_tb.sv
`timescale 1ns/1ps

module rx_mac_tb;

    // One expected output beat
    typedef struct packed {
        rx_mac_pkg::byte_t data;
        logic              last;
        logic              user;
    } beat_t;

    // Payload bytes over all tests, including the runt and the preamble-only frame
    localparam int PAYLOAD_BYTES  = 3 * 20 + (10 + 17 + 24 + 31 + 38 + 45) + 100 + 3;
    localparam int FRAMES         = 12;
    // Preamble, SFD, FCS, gap and drain slack per frame
    localparam int FRAME_OVERHEAD = 44;
    localparam int CYCLE_LIMIT    = 3 * (PAYLOAD_BYTES + FRAMES * FRAME_OVERHEAD) + 500;

    logic                  clk = 1'b0;
    logic                  rst;
    rx_mac_pkg::byte_t     rx_data;
    logic                  rx_dv;
    logic                  rx_er;
    rx_mac_pkg::byte_t     tdata;
    logic                  tvalid;
    logic                  tlast;
    logic                  tuser;
    logic                  trdy;
    rx_mac_pkg::rx_stats_t stats;

    beat_t             exp_q [$];
    rx_mac_pkg::byte_t payload_q [$];
    logic [31:0]       lfsr = 32'hdd86_080d;
    logic              random_trdy;

    int errors     = 0;
    int err_mark   = 0;
    int test_num   = 0;
    int beats      = 0;
    int cycles     = 0;
    int exp_frames = 0;
    int exp_bad    = 0;

    rx_mac UUT (
        .clk               (clk),
        .rst               (rst),
        .rgmii_mac_rx_data (rx_data),
        .rgmii_mac_rx_dv   (rx_dv),
        .rgmii_mac_rx_er   (rx_er),
        .m_rx_axis_tdata   (tdata),
        .m_rx_axis_tvalid  (tvalid),
        .m_rx_axis_tlast   (tlast),
        .m_rx_axis_tuser   (tuser),
        .s_rx_axis_trdy    (trdy),
        .stats             (stats)
    );

    always #10 clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[6:0], lfsr[0]};
        end
    endtask

    // Reference CRC-32, reflected, one data bit at a time
    function automatic logic [31:0] crc_update(input logic [31:0] crc,
                                               input rx_mac_pkg::byte_t b);
        logic [31:0] c;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            if (c[0] ^ b[i]) begin
                c = (c >> 1) ^ 32'hEDB8_8320;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    // Every input change happens here, on the falling edge
    task automatic advance_cycle();
        logic [7:0] r;
        @(negedge clk);
        if (random_trdy) begin
            // Ready three cycles out of four
            random_bits(2, r);
            trdy = (r[1:0] != 2'b00);
        end
    endtask

    task automatic drive_byte(input rx_mac_pkg::byte_t b, input logic er);
        advance_cycle();
        rx_dv   = 1'b1;
        rx_data = b;
        rx_er   = er;
    endtask

    task automatic make_payload(input int n);
        logic [7:0] b;
        payload_q.delete();
        repeat (n) begin
            random_bits(8, b);
            payload_q.push_back(b);
        end
    endtask

    // Queue the first n payload bytes as one frame
    task automatic expect_frame(input int n, input logic bad);
        for (int i = 0; i < n; i++) begin
            exp_q.push_back({payload_q[i], i == n - 1, bad && (i == n - 1)});
        end
        exp_frames++;
        if (bad) begin
            exp_bad++;
        end
    endtask

    // er_at indexes the bytes after the SFD, -1 for none
    task automatic send_frame(input logic with_sfd, input logic with_fcs,
                              input logic bad_fcs, input int er_at, input int gap);
        logic [31:0] crc;
        logic [31:0] fcs;
        int          idx;
        crc = 32'hFFFF_FFFF;
        foreach (payload_q[i]) begin
            crc = crc_update(crc, payload_q[i]);
        end
        fcs = ~crc;
        if (bad_fcs) begin
            fcs = fcs ^ 32'h0000_0100;
        end
        idx = 0;
        repeat (7) drive_byte(rx_mac_pkg::PREAMBLE_BYTE, 1'b0);
        if (with_sfd) begin
            drive_byte(rx_mac_pkg::SFD_BYTE, 1'b0);
        end
        foreach (payload_q[i]) begin
            drive_byte(payload_q[i], idx == er_at);
            idx++;
        end
        if (with_fcs) begin
            // FCS goes out least significant byte first
            for (int k = 0; k < 4; k++) begin
                drive_byte(fcs[8*k +: 8], idx == er_at);
                idx++;
            end
        end
        advance_cycle();
        rx_dv   = 1'b0;
        rx_er   = 1'b0;
        rx_data = '0;
        repeat (gap - 1) advance_cycle();
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            advance_cycle();
        end
    endtask

    task automatic end_test(input string name);
        test_num++;
        $display("test %0d %s: %0d error(s)", test_num, name, errors - err_mark);
        err_mark = errors;
    endtask

    // Scoreboard, one compare per accepted beat
    always @(posedge clk) begin : monitor
        beat_t got;
        beat_t want;
        if (!rst && tvalid && trdy) begin
            got = {tdata, tlast, tuser};
            assert (exp_q.size() != 0) else begin
                $display("Unexpected beat at %0t when no frame was pending", $time);
                errors++;
            end
            if (exp_q.size() != 0) begin
                want = exp_q.pop_front();
                assert (got == want) else begin
                    $display("FAIL %0t: beat %0d got %h/%b/%b, expected %h/%b/%b", $time,
                             beats, got.data, got.last, got.user,
                             want.data, want.last, want.user);
                    errors++;
                end
            end
            beats++;
        end
    end

    hold_check: assert property (@(posedge clk) disable iff (rst)
        (tvalid && !trdy) |=> (tvalid && $stable(tdata) && $stable(tlast) && $stable(tuser)))
        else begin
            $display("FAIL %0t: beat changed while trdy was low", $time);
            errors++;
        end

    reset_check: assert property (@(posedge clk) rst |=> !tvalid)
        else begin
            $display("FAIL %0t: tvalid high after reset", $time);
            errors++;
        end

    known_check: assert property (@(posedge clk) disable iff (rst) !$isunknown(tvalid))
        else begin
            $display("FAIL %0t: tvalid is unknown", $time);
            errors++;
        end

    initial begin : watchdog
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the DUT stopped delivering beats", cycles);
        $display("Test failed");
        $finish;
    end

    initial begin
        rst         = 1'b1;
        rx_data     = '0;
        rx_dv       = 1'b0;
        rx_er       = 1'b0;
        trdy        = 1'b1;
        random_trdy = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        make_payload(20);
        expect_frame(20, 1'b0);
        send_frame(1'b1, 1'b1, 1'b0, -1, 12);
        wait_drain();
        end_test("good frame");

        make_payload(20);
        expect_frame(20, 1'b1);
        send_frame(1'b1, 1'b1, 1'b1, -1, 12);
        wait_drain();
        end_test("wrong FCS");

        make_payload(20);
        expect_frame(20, 1'b1);
        send_frame(1'b1, 1'b1, 1'b0, 10, 12);
        wait_drain();
        end_test("rx_er in frame");

        random_trdy = 1'b1;
        for (int f = 0; f < 6; f++) begin
            make_payload(10 + 7 * f);
            expect_frame(10 + 7 * f, 1'b0);
            send_frame(1'b1, 1'b1, 1'b0, -1, 2);
        end
        wait_drain();
        random_trdy = 1'b0;
        advance_cycle();
        trdy = 1'b1;
        end_test("back-to-back, random trdy");

        // Output stalled, FIFO overflows and the frame is cut
        trdy = 1'b0;
        make_payload(100);
        expect_frame(rx_mac_pkg::FIFO_DEPTH, 1'b1);
        send_frame(1'b1, 1'b1, 1'b0, -1, 12);
        repeat (8) advance_cycle();
        trdy = 1'b1;
        wait_drain();
        repeat (10) advance_cycle();
        end_test("overflow");

        payload_q.delete();
        send_frame(1'b0, 1'b0, 1'b0, -1, 12);
        make_payload(3);
        send_frame(1'b1, 1'b0, 1'b0, -1, 12);
        repeat (10) advance_cycle();
        assert (stats.frame_count == exp_frames) else begin
            $display("FAIL %0t: frame_count %0d, expected %0d", $time,
                     stats.frame_count, exp_frames);
            errors++;
        end
        assert (stats.bad_frame_count == exp_bad) else begin
            $display("FAIL %0t: bad_frame_count %0d, expected %0d", $time,
                     stats.bad_frame_count, exp_bad);
            errors++;
        end
        end_test("no SFD, runt, stats");

        $display("%0d tests, %0d beats, %0d frames, %0d errors",
                 test_num, beats, exp_frames, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- sources.f
rx_mac_pkg.sv
rx_crc32.sv
rx_frame_parser.sv
rx_frame_fifo.sv
rx_axis_out.sv
rx_mac.sv
rx_mac_tb.sv
